// File: Bender.yml
package:
  name: packet_link

sources:
  - hw/packet_link_pkg.sv
  - hw/packet_sender.sv
  - hw/beat_fifo.sv
  - hw/packet_receiver.sv
  - hw/packet_link.sv
  - target: test
    files:
      - test/packet_link_tb.sv

// File: hw/beat_fifo.sv
`timescale 1ns/1ps

module beat_fifo import packet_link_pkg::*; #(
  parameter int DEPTH = FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     reset_n,
  input  st_beat_t in_beat,
  input  logic     in_valid,
  output logic     in_ready,
  output st_beat_t out_beat,
  output logic     out_valid,
  input  logic     out_ready
);

  st_beat_t mem [DEPTH];

  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic                       push;
  logic                       pop;

  assign out_valid = (count != 0);
  // a full fifo still takes a beat in the cycle it is read
  assign in_ready  = (count != DEPTH) || out_ready;
  assign out_beat  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_beat;
    end
  end

endmodule

// File: hw/packet_link.sv
`timescale 1ns/1ps

module packet_link import packet_link_pkg::*; (
  input  logic    clk,
  input  logic    reset_n,
  input  logic    write_packet,
  input  packet_t packet_data,
  output logic    sending,
  output packet_t packet_out,
  output logic    packet_valid,
  input  logic    packet_ready
);

  // sender to fifo
  st_beat_t tx_beat;
  logic     tx_valid;
  logic     tx_ready;

  // fifo to receiver
  st_beat_t rx_beat;
  logic     rx_valid;
  logic     rx_ready;

  packet_sender u_sender (
    .clk          (clk),
    .reset_n      (reset_n),
    .write_packet (write_packet),
    .packet_data  (packet_data),
    .tx_ready     (tx_ready),
    .tx_beat      (tx_beat),
    .tx_valid     (tx_valid),
    .sending      (sending)
  );

  beat_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_beat   (tx_beat),
    .in_valid  (tx_valid),
    .in_ready  (tx_ready),
    .out_beat  (rx_beat),
    .out_valid (rx_valid),
    .out_ready (rx_ready)
  );

  packet_receiver u_receiver (
    .clk          (clk),
    .reset_n      (reset_n),
    .rx_beat      (rx_beat),
    .rx_valid     (rx_valid),
    .rx_ready     (rx_ready),
    .packet_out   (packet_out),
    .packet_valid (packet_valid),
    .packet_ready (packet_ready)
  );

endmodule

// File: hw/packet_link_pkg.sv
package packet_link_pkg;

  // stream sizing
  localparam int BEAT_WIDTH       = 32;
  localparam int EMPTY_WIDTH      = 2;
  localparam int BEATS_PER_PACKET = 8;
  localparam int FIFO_DEPTH       = 16;

  // one endpoint on the link
  typedef struct packed {
    logic [31:0] hw_addr;
    logic [7:0]  sw_addr;
    logic [7:0]  port;
    logic [7:0]  flag;
  } node_addr_t;

  // complete message of 240 bits
  typedef struct packed {
    node_addr_t  dest_addr;
    node_addr_t  src_addr;
    logic [31:0] lamport;
    logic [95:0] data;
  } packet_t;

  // one avalon-st beat with its sideband bits
  typedef struct packed {
    logic [BEAT_WIDTH-1:0]  data;
    logic                   startofpacket;
    logic                   endofpacket;
    logic [EMPTY_WIDTH-1:0] empty;
  } st_beat_t;

  // sender position inside the packet with one state per beat
  typedef enum logic [3:0] {
    IDLE,
    DEST_HW,
    DEST_SW,
    SRC_HW,
    SRC_SW,
    LAMPORT,
    DATA0,
    DATA1,
    DATA2
  } sender_state_t;

endpackage

// File: hw/packet_receiver.sv
`timescale 1ns/1ps

module packet_receiver import packet_link_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  st_beat_t rx_beat,
  input  logic     rx_valid,
  output logic     rx_ready,
  output packet_t  packet_out,
  output logic     packet_valid,
  input  logic     packet_ready
);

  logic [$clog2(BEATS_PER_PACKET)-1:0] beat_idx;
  logic [$clog2(BEATS_PER_PACKET)-1:0] wr_idx;
  logic                                take;

  // stall the stream while a finished packet waits
  assign rx_ready = !packet_valid || packet_ready;
  assign take     = rx_valid && rx_ready;

  // startofpacket always lands in the first field
  assign wr_idx = rx_beat.startofpacket ? '0 : beat_idx;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      beat_idx     <= '0;
      packet_valid <= 1'b0;
    end else begin
      if (take) begin
        beat_idx <= rx_beat.endofpacket ? '0 : wr_idx + 1'b1;
      end

      if (take && rx_beat.endofpacket) begin
        packet_valid <= 1'b1;
      end else if (packet_ready) begin
        packet_valid <= 1'b0;
      end
    end
  end

  // the low byte of the sw address beats is padding
  always_ff @(posedge clk) begin
    if (take) begin
      case (wr_idx)
        3'd0: packet_out.dest_addr.hw_addr <= rx_beat.data;
        3'd1: begin
          {packet_out.dest_addr.sw_addr, packet_out.dest_addr.port,
           packet_out.dest_addr.flag} <= rx_beat.data[31:8];
        end
        3'd2: packet_out.src_addr.hw_addr <= rx_beat.data;
        3'd3: begin
          {packet_out.src_addr.sw_addr, packet_out.src_addr.port,
           packet_out.src_addr.flag} <= rx_beat.data[31:8];
        end
        3'd4: packet_out.lamport <= rx_beat.data;
        3'd5: packet_out.data[31:0] <= rx_beat.data;
        3'd6: packet_out.data[63:32] <= rx_beat.data;
        default: packet_out.data[95:64] <= rx_beat.data;
      endcase
    end
  end

endmodule

// File: hw/packet_sender.sv
`timescale 1ns/1ps

module packet_sender import packet_link_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     write_packet,
  input  packet_t  packet_data,
  input  logic     tx_ready,
  output st_beat_t tx_beat,
  output logic     tx_valid,
  output logic     sending
);

  sender_state_t state;
  sender_state_t next_state;
  packet_t       pkt_reg;
  st_beat_t      payload;
  st_beat_t      next_beat;
  logic          payload_valid;
  logic          stage_ready;
  logic          accept_write;
  logic          load_payload;
  logic          move_payload;

  assign sending = (state != IDLE);

  // output register can take a new beat when empty or being drained
  assign stage_ready  = tx_ready || !tx_valid;
  assign accept_write = write_packet && (state == IDLE);
  assign load_payload = (state != IDLE) && stage_ready;
  assign move_payload = payload_valid && stage_ready;

  // beat contents and successor for each state
  always_comb begin
    next_beat  = '0;
    next_state = state;
    case (state)
      DEST_HW: begin
        next_beat.data          = pkt_reg.dest_addr.hw_addr;
        next_beat.startofpacket = 1'b1;
        next_state              = DEST_SW;
      end
      DEST_SW: begin
        next_beat.data = {pkt_reg.dest_addr.sw_addr, pkt_reg.dest_addr.port,
                          pkt_reg.dest_addr.flag, 8'h00};
        next_state     = SRC_HW;
      end
      SRC_HW: begin
        next_beat.data = pkt_reg.src_addr.hw_addr;
        next_state     = SRC_SW;
      end
      SRC_SW: begin
        next_beat.data = {pkt_reg.src_addr.sw_addr, pkt_reg.src_addr.port,
                          pkt_reg.src_addr.flag, 8'h00};
        next_state     = LAMPORT;
      end
      LAMPORT: begin
        next_beat.data = pkt_reg.lamport;
        next_state     = DATA0;
      end
      DATA0: begin
        next_beat.data = pkt_reg.data[31:0];
        next_state     = DATA1;
      end
      DATA1: begin
        next_beat.data = pkt_reg.data[63:32];
        next_state     = DATA2;
      end
      DATA2: begin
        next_beat.data        = pkt_reg.data[95:64];
        next_beat.endofpacket = 1'b1;
        next_state            = IDLE;
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state         <= IDLE;
      payload_valid <= 1'b0;
      tx_valid      <= 1'b0;
    end else begin
      if (accept_write) begin
        state <= DEST_HW;
      end else if (load_payload) begin
        state <= next_state;
      end

      // a fresh load wins over the payload moving on
      if (load_payload) begin
        payload_valid <= 1'b1;
      end else if (move_payload) begin
        payload_valid <= 1'b0;
      end

      if (move_payload) begin
        tx_valid <= 1'b1;
      end else if (tx_ready) begin
        tx_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept_write) begin
      pkt_reg <= packet_data;
    end
    if (load_payload) begin
      payload <= next_beat;
    end
    if (move_payload) begin
      tx_beat <= payload;
    end
  end

endmodule

// File: list.f
hw/packet_link_pkg.sv
hw/packet_sender.sv
hw/beat_fifo.sv
hw/packet_receiver.sv
hw/packet_link.sv
test/packet_link_tb.sv

// File: test/packet_link_tb.sv
`timescale 1ns/1ps

module packet_link_tb import packet_link_pkg::*; ();

  localparam int TOTAL_PACKETS = 101;
  localparam int CLK_PERIOD    = 8;
  localparam int TIMEOUT_NS    = TOTAL_PACKETS * BEATS_PER_PACKET * 20 * CLK_PERIOD;

  logic    clk;
  logic    reset_n;
  logic    write_packet;
  packet_t packet_data;
  logic    sending;
  packet_t packet_out;
  logic    packet_valid;
  logic    packet_ready;

  packet_t expected_q[$];
  int      pass_count;
  int      fail_count;
  int      test_errors_start;
  int      delivered_count;
  int      ignored_count;
  bit      stall_mode;
  int      run_left;
  bit      run_level;
  bit      hold_valid;
  packet_t hold_pkt;
  packet_t exp_pkt;

  packet_link u_packet_link (
    .clk          (clk),
    .reset_n      (reset_n),
    .write_packet (write_packet),
    .packet_data  (packet_data),
    .sending      (sending),
    .packet_out   (packet_out),
    .packet_valid (packet_valid),
    .packet_ready (packet_ready)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(input logic [239:0] got, input logic [239:0] exp,
                             input string msg);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  function automatic packet_t random_packet();
    logic [255:0] raw;
    raw = '0;
    for (int i = 0; i < 8; i++) begin
      raw = {raw[223:0], $urandom};
    end
    return raw[239:0];
  endfunction

  // writes one packet as soon as the sender is idle
  task automatic send_one_packet(input bit strobe_while_busy);
    while (sending) begin
      @(posedge clk);
      #1;
    end
    write_packet = 1'b1;
    packet_data  = random_packet();
    @(posedge clk);
    #1;
    write_packet = 1'b0;
    // extra strobes land on edges where sending is still high
    if (strobe_while_busy) begin
      while (sending) begin
        if ($urandom % 2) begin
          write_packet = 1'b1;
          packet_data  = random_packet();
        end
        @(posedge clk);
        #1;
        write_packet = 1'b0;
      end
    end
  endtask

  task automatic drain_queue();
    int waited;
    int limit;
    waited = 0;
    limit  = expected_q.size() * BEATS_PER_PACKET * 20 + 100;
    while (expected_q.size() != 0 && waited < limit) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (expected_q.size() != 0) begin
      $display("%0d packets were never delivered", expected_q.size());
      fail_count += expected_q.size();
      expected_q.delete();
    end
    // quiet period to catch any extra packet on the output
    repeat (30) @(posedge clk);
    #1;
  endtask

  task automatic report_test(input string name);
    $display("test %s finished with %0d errors", name, fail_count - test_errors_start);
    test_errors_start = fail_count;
    delivered_count   = 0;
  endtask

  // output stall pattern in long runs so the fifo fills up
  always begin
    @(posedge clk);
    #1;
    if (stall_mode) begin
      if (run_left == 0) begin
        run_left  = 1 + $urandom % 40;
        run_level = $urandom % 2;
      end
      packet_ready = run_level;
      run_left--;
    end else begin
      packet_ready = 1'b1;
    end
  end

  // reference model and output checks
  always @(posedge clk) begin
    if (reset_n) begin
      if (write_packet) begin
        if (!sending) begin
          expected_q.push_back(packet_data);
        end else begin
          ignored_count++;
        end
      end
      if (hold_valid) begin
        check_value(packet_valid, 1'b1, "packet_valid dropped before packet_ready");
        check_value(packet_out, hold_pkt, "packet_out changed while stalled");
      end
      if (packet_valid && packet_ready) begin
        delivered_count++;
        if (expected_q.size() == 0) begin
          $display("a packet came out at %0t ns when none was expected", $time);
          fail_count++;
        end else begin
          exp_pkt = expected_q.pop_front();
          check_value(packet_out, exp_pkt, "delivered packet");
        end
      end
      hold_valid = packet_valid && !packet_ready;
      hold_pkt   = packet_out;
    end
  end

  initial begin
    void'($urandom(73));
    clk               = 1'b0;
    reset_n           = 1'b0;
    write_packet      = 1'b0;
    packet_data       = '0;
    packet_ready      = 1'b1;
    pass_count        = 0;
    fail_count        = 0;
    test_errors_start = 0;
    delivered_count   = 0;
    ignored_count     = 0;
    stall_mode        = 1'b0;
    run_left          = 0;
    run_level         = 1'b1;
    hold_valid        = 1'b0;

    fork
      begin
        #(TIMEOUT_NS);
        $display("timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Something failed");
        $finish;
      end
    join_none

    repeat (4) @(posedge clk);
    #1;
    check_value(sending, 1'b0, "sending during reset");
    check_value(packet_valid, 1'b0, "packet_valid during reset");
    repeat (4) @(posedge clk);
    #1;
    reset_n = 1'b1;
    @(posedge clk);
    #1;
    check_value(sending, 1'b0, "sending after reset");
    check_value(packet_valid, 1'b0, "packet_valid after reset");
    report_test("reset_state");

    send_one_packet(1'b0);
    drain_queue();
    check_value(delivered_count, 1, "single packet delivery count");
    report_test("single_packet");

    repeat (40) send_one_packet(1'b0);
    drain_queue();
    check_value(delivered_count, 40, "back-to-back delivery count");
    report_test("back_to_back");

    stall_mode = 1'b1;
    repeat (40) send_one_packet(1'b0);
    drain_queue();
    stall_mode = 1'b0;
    check_value(delivered_count, 40, "back-pressure delivery count");
    report_test("back_pressure");

    ignored_count = 0;
    repeat (20) send_one_packet(1'b1);
    drain_queue();
    check_value(delivered_count, 20, "delivery count with ignored writes");
    check_value(ignored_count != 0, 1'b1, "ignored strobes were driven");
    report_test("ignored_writes");

    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
